//--- rtl/scaler_pkg.sv
package scaler_pkg;

    // One bus request as driven by the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [6:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // What a bus access points at
    typedef enum logic [1:0] {
        ACC_CONTROL = 2'd0,
        ACC_ENABLE  = 2'd1,
        ACC_SCALER  = 2'd2
    } access_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_CYCLE = 2'd1,
        ST_ACK   = 2'd2
    } bus_state_e;

    // Gate sources, GP0..GP5 map onto gp_gate_i bits 0..5
    typedef enum logic [2:0] {
        GATE_OFF = 3'd0,
        GATE_GP0 = 3'd1,
        GATE_GP1 = 3'd2,
        GATE_GP2 = 3'd3,
        GATE_GP3 = 3'd4,
        GATE_GP4 = 3'd5,
        GATE_GP5 = 3'd6,
        GATE_PPS = 3'd7
    } gate_src_e;

    // Gate and per-channel enables going to the counters
    typedef struct packed {
        logic        gate;
        logic [31:0] chan_en;
    } scaler_gate_t;

    localparam logic [6:0] GATE_CTRL_ADDR = 7'h00;
    localparam logic [6:0] GATE_EN_ADDR   = 7'h04;

    // Scaler reads live above this bit, channel index sits in adr[5:2]
    localparam int SCALER_ADR_BIT = 6;

endpackage

//--- rtl/scaler_reg_core.sv
module scaler_reg_core #(
    parameter int NUM_CH = 8,
    parameter int CNT_W  = 16
) (
    input  logic                     sysclk_i,
    input  logic                     wb_rst_i,
    input  scaler_pkg::wb_req_t      wb_req_i,
    input  logic                     pps_i,
    input  logic [5:0]               gp_gate_i,
    input  logic [CNT_W-1:0]         rd_count_i,
    output logic                     wb_ack_o,
    output logic [31:0]              wb_dat_o,
    output scaler_pkg::scaler_gate_t gate_o,
    output logic [3:0]               rd_ch_o
);

    // Only the low NUM_CH enable bits reach the counters
    localparam logic [31:0] CH_MASK = 32'((33'd1 << NUM_CH) - 33'd1);

    scaler_pkg::bus_state_e   state_q;
    scaler_pkg::access_kind_e acc_kind_d;
    scaler_pkg::access_kind_e acc_kind_q;
    logic                     acc_we_q;
    logic [31:0]              dat_q;
    logic [3:0]               rd_ch_q;
    logic                     req;

    scaler_pkg::gate_src_e    gate_sel_q;
    logic [15:0]              gatelen_q;
    logic [31:0]              enable_q;

    logic [5:0]               gp_q;
    logic                     pps_gate_q;
    logic [15:0]              pps_cnt_q;
    logic                     gate_q;
    logic [7:0]               gate_in;

    assign req = wb_req_i.cyc & wb_req_i.stb;

    always_comb begin
        if (wb_req_i.adr[scaler_pkg::SCALER_ADR_BIT]) begin
            acc_kind_d = scaler_pkg::ACC_SCALER;
        end else if (wb_req_i.adr == scaler_pkg::GATE_EN_ADDR) begin
            acc_kind_d = scaler_pkg::ACC_ENABLE;
        end else begin
            acc_kind_d = scaler_pkg::ACC_CONTROL; // Anything else lands on the control word
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            state_q    <= scaler_pkg::ST_IDLE;
            acc_kind_q <= scaler_pkg::ACC_CONTROL;
            acc_we_q   <= 1'b0;
            dat_q      <= '0;
            rd_ch_q    <= '0;
            gate_sel_q <= scaler_pkg::GATE_OFF;
            gatelen_q  <= '0;
            enable_q   <= '0;
        end else begin
            case (state_q)
                scaler_pkg::ST_IDLE: begin
                    if (req) begin
                        state_q    <= scaler_pkg::ST_CYCLE;
                        acc_kind_q <= acc_kind_d;
                        acc_we_q   <= wb_req_i.we;
                        dat_q      <= wb_req_i.dat; // Write data waits here for one cycle
                        rd_ch_q    <= wb_req_i.adr[5:2];
                    end
                end
                scaler_pkg::ST_CYCLE: begin
                    state_q <= scaler_pkg::ST_ACK;
                    if (acc_we_q) begin
                        case (acc_kind_q)
                            scaler_pkg::ACC_CONTROL: begin
                                gate_sel_q <= scaler_pkg::gate_src_e'(dat_q[2:0]);
                                gatelen_q  <= dat_q[31:16];
                            end
                            scaler_pkg::ACC_ENABLE: enable_q <= dat_q;
                            default: ; // Scaler counts are read only
                        endcase
                    end else begin
                        case (acc_kind_q)
                            scaler_pkg::ACC_CONTROL: dat_q <= {gatelen_q, 13'd0, gate_sel_q};
                            scaler_pkg::ACC_ENABLE:  dat_q <= enable_q;
                            default:                 dat_q <= 32'(rd_count_i);
                        endcase
                    end
                end
                scaler_pkg::ST_ACK: state_q <= scaler_pkg::ST_IDLE;
                default:            state_q <= scaler_pkg::ST_IDLE;
            endcase
        end
    end

    // Index 0 is the off source, so gp bit n sits at index n+1
    assign gate_in = {pps_gate_q, gp_q, 1'b0};

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            gp_q       <= '0;
            gate_q     <= 1'b0;
            pps_gate_q <= 1'b0;
            pps_cnt_q  <= '0;
        end else begin
            gp_q   <= gp_gate_i;
            gate_q <= gate_in[gate_sel_q];

            // A PPS sample opens the gate for gatelen+1 cycles
            if (gate_sel_q == scaler_pkg::GATE_PPS && pps_i) begin
                pps_gate_q <= 1'b1;
            end else if (pps_cnt_q == gatelen_q) begin
                pps_gate_q <= 1'b0;
            end

            if (!pps_gate_q) begin
                pps_cnt_q <= '0;
            end else begin
                pps_cnt_q <= pps_cnt_q + 16'd1;
            end
        end
    end

    assign wb_ack_o       = (state_q == scaler_pkg::ST_ACK);
    assign wb_dat_o       = dat_q;
    assign rd_ch_o        = rd_ch_q;
    assign gate_o.gate    = gate_q;
    assign gate_o.chan_en = enable_q & CH_MASK;

endmodule

//--- rtl/scaler_counter_bank.sv
module scaler_counter_bank #(
    parameter int NUM_CH        = 8,
    parameter int CNT_W         = 16,
    parameter int PERIOD_CYCLES = 1000
) (
    input  logic                     sysclk_i,
    input  logic                     wb_rst_i,
    input  logic [NUM_CH-1:0]        trig_i,
    input  scaler_pkg::scaler_gate_t gate_i,
    input  logic [3:0]               rd_ch_i,
    output logic [CNT_W-1:0]         rd_count_o,
    output logic                     update_o
);

    localparam int               TMR_W    = $clog2(PERIOD_CYCLES);
    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(PERIOD_CYCLES - 1);

    logic [NUM_CH-1:0] trig_q;
    logic [NUM_CH-1:0] hit;
    logic [CNT_W-1:0]  cnt_q [NUM_CH];
    logic [CNT_W-1:0]  cnt_d [NUM_CH];
    logic [CNT_W-1:0]  latch_q [NUM_CH];
    logic [TMR_W-1:0]  tmr_q;
    logic              period_end;
    logic              update_q;

    assign period_end = (tmr_q == TMR_LAST);

    // Next count per channel, held at all ones once full
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            hit[c] = trig_q[c] & gate_i.gate & gate_i.chan_en[c];
            if (hit[c] && cnt_q[c] != '1) begin
                cnt_d[c] = cnt_q[c] + 1'b1;
            end else begin
                cnt_d[c] = cnt_q[c];
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            trig_q   <= '0;
            tmr_q    <= '0;
            update_q <= 1'b0;
            for (int c = 0; c < NUM_CH; c++) begin
                cnt_q[c]   <= '0;
                latch_q[c] <= '0;
            end
        end else begin
            trig_q   <= trig_i;
            update_q <= period_end;

            if (period_end) begin
                tmr_q <= '0;
            end else begin
                tmr_q <= tmr_q + 1'b1;
            end

            for (int c = 0; c < NUM_CH; c++) begin
                if (period_end) begin
                    latch_q[c] <= cnt_d[c]; // A hit on the last cycle still counts
                    cnt_q[c]   <= '0;
                end else begin
                    cnt_q[c] <= cnt_d[c];
                end
            end
        end
    end

    // Channels past NUM_CH read as zero
    always_comb begin
        rd_count_o = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (rd_ch_i == 4'(c)) begin
                rd_count_o = latch_q[c];
            end
        end
    end

    assign update_o = update_q;

endmodule

//--- rtl/scaler_top.sv
module scaler_top #(
    parameter int NUM_CH        = 8,
    parameter int CNT_W         = 16,
    parameter int PERIOD_CYCLES = 1000
) (
    input  logic                sysclk_i,
    input  logic                wb_rst_i,
    input  scaler_pkg::wb_req_t wb_req_i,
    input  logic                pps_i,
    input  logic [5:0]          gp_gate_i,
    input  logic [NUM_CH-1:0]   trig_i,
    output logic                wb_ack_o,
    output logic [31:0]         wb_dat_o,
    output logic                gate_o,
    output logic                update_o
);

    scaler_pkg::scaler_gate_t gate_bus;
    logic [3:0]               rd_ch;
    logic [CNT_W-1:0]         rd_count;

    scaler_reg_core #(
        .NUM_CH (NUM_CH),
        .CNT_W  (CNT_W)
    ) u_reg_core (
        .sysclk_i   (sysclk_i),
        .wb_rst_i   (wb_rst_i),
        .wb_req_i   (wb_req_i),
        .pps_i      (pps_i),
        .gp_gate_i  (gp_gate_i),
        .rd_count_i (rd_count),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .gate_o     (gate_bus),
        .rd_ch_o    (rd_ch)
    );

    scaler_counter_bank #(
        .NUM_CH        (NUM_CH),
        .CNT_W         (CNT_W),
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) u_counter_bank (
        .sysclk_i   (sysclk_i),
        .wb_rst_i   (wb_rst_i),
        .trig_i     (trig_i),
        .gate_i     (gate_bus),
        .rd_ch_i    (rd_ch),
        .rd_count_o (rd_count),
        .update_o   (update_o)
    );

    assign gate_o = gate_bus.gate; // Enables stay internal

endmodule

//--- dv/scaler_tb_tasks.svh
`ifndef SCALER_TB_TASKS_SVH
`define SCALER_TB_TASKS_SVH

// Drives and samples both happen just after the rising edge
task automatic next_cycle();
    @(posedge sysclk_i);
    #1;
endtask

task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Testbench stopped on the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        stop_on_failure();
    end
endtask

// Holds the request until the one-cycle acknowledge, then idles a cycle
task automatic bus_access(input logic we, input logic [6:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int waited;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    waited = 0;
    next_cycle();
    while (!wb_ack_o) begin
        if (waited == ACK_LIMIT) begin
            $display("No acknowledge from the DUT for address 0x%02h within %0d cycles",
                     adr, ACK_LIMIT);
            stop_on_failure();
        end
        waited++;
        next_cycle();
    end
    // The acknowledge comes two cycles after the request is sampled
    check_value($sformatf("ack delay 0x%02h", adr), 32'd1, 32'(waited));
    rdat   = wb_dat_o;
    wb_req = '0;
    next_cycle();
    check_value($sformatf("ack width 0x%02h", adr), 32'd0, 32'(wb_ack_o));
endtask

task automatic bus_write(input logic [6:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, unused);
endtask

task automatic bus_read(input logic [6:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'd0, dat);
endtask

task automatic wait_update();
    int waited;
    waited = 0;
    next_cycle();
    while (!update_o) begin
        if (waited == 2 * PERIOD_CYCLES) begin
            $display("update_o did not pulse within %0d cycles", waited);
            stop_on_failure();
        end
        waited++;
        next_cycle();
    end
endtask

`endif

//--- dv/scaler_tb.sv
module scaler_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CH         = 4;
    localparam int CNT_W          = 8;
    localparam int PERIOD_CYCLES  = 64;
    localparam int CNT_MAX        = (1 << CNT_W) - 1;
    localparam int NUM_ROWS       = 5;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 * PERIOD_CYCLES + 500;
    localparam int ACK_LIMIT      = 8;
    localparam int PULSE_FIRST    = 8; // Pulses stay clear of both period edges
    localparam int PULSE_LAST     = PERIOD_CYCLES - 8;
    localparam logic [31:0] RAND_SEED = 32'h360cd4d2;

    // One counting case with pulse counts listed from channel 3 down to channel 0
    typedef struct packed {
        scaler_pkg::gate_src_e   src;
        logic [15:0]             gatelen;
        logic [31:0]             enable;
        logic [5:0]              gp_level;
        logic [3:0][7:0]         pulses;
    } case_t;

    logic                sysclk_i;
    logic                wb_rst_i;
    scaler_pkg::wb_req_t wb_req;
    logic                pps_i;
    logic [5:0]          gp_gate_i;
    logic [NUM_CH-1:0]   trig_i;
    logic                wb_ack_o;
    logic [31:0]         wb_dat_o;
    logic                gate_o;
    logic                update_o;

    case_t cases [NUM_ROWS];
    string case_names [NUM_ROWS];
    int    cycle_count;

    scaler_top #(
        .NUM_CH        (NUM_CH),
        .CNT_W         (CNT_W),
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) dut (
        .sysclk_i  (sysclk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_req_i  (wb_req),
        .pps_i     (pps_i),
        .gp_gate_i (gp_gate_i),
        .trig_i    (trig_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .gate_o    (gate_o),
        .update_o  (update_o)
    );

    `include "scaler_tb_tasks.svh"

    task automatic load_cases();
        case_names[0] = "all_open_gp0";
        cases[0] = '{src: scaler_pkg::GATE_GP0, gatelen: 16'd0, enable: 32'h0000_000f,
                     gp_level: 6'h01, pulses: {8'd40, 8'd3, 8'd17, 8'd5}};
        case_names[1] = "partial_enable_gp3";
        cases[1] = '{src: scaler_pkg::GATE_GP3, gatelen: 16'd2, enable: 32'h0000_0005,
                     gp_level: 6'h08, pulses: {8'd1, 8'd30, 8'd9, 8'd12}};
        case_names[2] = "high_enable_bits_gp5";
        cases[2] = '{src: scaler_pkg::GATE_GP5, gatelen: 16'd7, enable: 32'hffff_fff2,
                     gp_level: 6'h20, pulses: {8'd48, 8'd14, 8'd22, 8'd7}};
        case_names[3] = "gate_off";
        cases[3] = '{src: scaler_pkg::GATE_OFF, gatelen: 16'd0, enable: 32'h0000_000f,
                     gp_level: 6'h3f, pulses: {8'd10, 8'd10, 8'd10, 8'd10}};
        case_names[4] = "gp2_held_low";
        cases[4] = '{src: scaler_pkg::GATE_GP2, gatelen: 16'd0, enable: 32'h0000_000f,
                     gp_level: 6'h3b, pulses: {8'd1, 8'd2, 8'd4, 8'd8}};
    endtask

    // PPS stays low in the counting cases, so only a gp source can open the gate
    function automatic logic gate_is_open(scaler_pkg::gate_src_e src, logic [5:0] gp);
        if (src == scaler_pkg::GATE_OFF || src == scaler_pkg::GATE_PPS) begin
            return 1'b0;
        end
        return gp[int'(src) - 1];
    endfunction

    function automatic int expected_count(logic open, logic en, int pulses);
        if (!open || !en) begin
            return 0;
        end
        return (pulses > CNT_MAX) ? CNT_MAX : pulses;
    endfunction

    task automatic drive_pulses(input logic [3:0][7:0] pulses);
        int         left [NUM_CH];
        int         slots_left;
        logic [NUM_CH-1:0] trig;
        for (int c = 0; c < NUM_CH; c++) begin
            left[c] = int'(pulses[c]);
        end
        for (int k = 0; k < PULSE_LAST; k++) begin
            trig = '0;
            if (k >= PULSE_FIRST) begin
                slots_left = PULSE_LAST - k;
                for (int c = 0; c < NUM_CH; c++) begin
                    if (left[c] > 0 && int'($urandom_range(32'(slots_left - 1))) < left[c]) begin
                        trig[c] = 1'b1;
                        left[c]--;
                    end
                end
            end
            trig_i = trig;
            next_cycle();
        end
        trig_i = '0;
    endtask

    task automatic check_reset_values();
        logic [31:0] rdata;
        check_value("reset gate_o", 32'd0, 32'(gate_o));
        check_value("reset update_o", 32'd0, 32'(update_o));
        bus_read(scaler_pkg::GATE_CTRL_ADDR, rdata);
        check_value("reset control", 32'd0, rdata);
        bus_read(scaler_pkg::GATE_EN_ADDR, rdata);
        check_value("reset enable", 32'd0, rdata);
        for (int ch = 0; ch < 16; ch++) begin
            bus_read({1'b1, 4'(ch), 2'b00}, rdata);
            check_value($sformatf("reset scaler %0d", ch), 32'd0, rdata);
        end
    endtask

    task automatic check_register_access();
        logic [31:0] rdata;
        bus_write(scaler_pkg::GATE_CTRL_ADDR, 32'hbeef_fffd);
        bus_read(scaler_pkg::GATE_CTRL_ADDR, rdata);
        check_value("control readback", 32'hbeef_0005, rdata); // Bits 15:3 read as zero
        bus_write(scaler_pkg::GATE_EN_ADDR, 32'ha5a5_5a5a);
        bus_read(scaler_pkg::GATE_EN_ADDR, rdata);
        check_value("enable readback", 32'ha5a5_5a5a, rdata);
        bus_write(7'h44, 32'hdead_beef);
        bus_read(7'h44, rdata);
        check_value("scaler write ignored", 32'd0, rdata); // No trigger has been counted yet
    endtask

    task automatic check_gp_gates();
        logic [5:0] sel_bit;
        for (int s = 1; s <= 6; s++) begin
            sel_bit = 6'(1 << (s - 1));
            bus_write(scaler_pkg::GATE_CTRL_ADDR, 32'(s));
            for (int level = 1; level >= 0; level--) begin
                gp_gate_i = (level == 1) ? sel_bit : ~sel_bit; // Other inputs opposite
                next_cycle();
                next_cycle();
                check_value($sformatf("gp%0d level %0d", s - 1, level), 32'(level),
                            32'(gate_o));
            end
        end
        bus_write(scaler_pkg::GATE_CTRL_ADDR, 32'd0);
        gp_gate_i = 6'h3f;
        next_cycle();
        next_cycle();
        check_value("gate off", 32'd0, 32'(gate_o));
        gp_gate_i = '0;
    endtask

    task automatic check_pps_gate(input logic [15:0] gatelen);
        int   high_cycles;
        int   rises;
        logic last;
        bus_write(scaler_pkg::GATE_CTRL_ADDR, {gatelen, 13'd0, scaler_pkg::GATE_PPS});
        check_value("pps idle", 32'd0, 32'(gate_o));
        pps_i = 1'b1;
        next_cycle();
        pps_i = 1'b0;
        high_cycles = 0;
        rises       = 0;
        last        = 1'b0;
        repeat (int'(gatelen) + 8) begin
            next_cycle();
            if (gate_o) high_cycles++;
            if (gate_o && !last) rises++;
            last = gate_o;
        end
        check_value($sformatf("pps width gatelen %0d", gatelen), 32'(gatelen) + 32'd1,
                    32'(high_cycles));
        check_value($sformatf("pps runs gatelen %0d", gatelen), 32'd1, 32'(rises));
    endtask

    task automatic run_count_case(input int idx);
        case_t       row;
        logic [31:0] rdata;
        logic        open;
        int          expected;
        row = cases[idx];
        gp_gate_i = row.gp_level;
        bus_write(scaler_pkg::GATE_CTRL_ADDR, {row.gatelen, 13'd0, row.src});
        bus_write(scaler_pkg::GATE_EN_ADDR, row.enable);
        bus_read(scaler_pkg::GATE_CTRL_ADDR, rdata);
        check_value({case_names[idx], " control"}, {row.gatelen, 13'd0, row.src}, rdata);
        bus_read(scaler_pkg::GATE_EN_ADDR, rdata);
        check_value({case_names[idx], " enable"}, row.enable, rdata);
        wait_update(); // Start of a period with the new settings in place
        drive_pulses(row.pulses);
        wait_update(); // This pulse latches the period that held the triggers
        open = gate_is_open(row.src, row.gp_level);
        for (int c = 0; c < NUM_CH; c++) begin
            expected = expected_count(open, row.enable[c], int'(row.pulses[c]));
            bus_read({1'b1, 4'(c), 2'b00}, rdata);
            check_value($sformatf("%s ch%0d", case_names[idx], c), 32'(expected), rdata);
        end
    endtask

    initial begin
        sysclk_i = 1'b0;
        forever #50 sysclk_i = ~sysclk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sysclk_i);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        stop_on_failure();
    end

    // Every update pulse after the first must follow the last by one period
    initial begin
        int since;
        bit seen;
        since = 0;
        seen  = 1'b0;
        forever begin
            next_cycle();
            if (wb_rst_i) begin
                since = 0;
                seen  = 1'b0;
            end else begin
                since++;
                if (update_o) begin
                    if (seen) check_value("update period", 32'(PERIOD_CYCLES), 32'(since));
                    seen  = 1'b1;
                    since = 0;
                end
            end
        end
    end

    initial begin
        wb_rst_i  = 1'b1;
        wb_req    = '0;
        pps_i     = 1'b0;
        gp_gate_i = '0;
        trig_i    = '0;
        void'($urandom(RAND_SEED));
        load_cases();
        repeat (8) @(posedge sysclk_i);
        #1 wb_rst_i = 1'b0;
        check_reset_values();
        check_register_access();
        check_gp_gates();
        check_pps_gate(16'd3);
        check_pps_gate(16'd9);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_count_case(i);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- list.f
+incdir+dv
rtl/scaler_pkg.sv
rtl/scaler_reg_core.sv
rtl/scaler_counter_bank.sv
rtl/scaler_top.sv
dv/scaler_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the scaler testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f list.f \
    --top-module scaler_tb \
    -Mdir obj_dir \
    -o scaler_sim \
    && ./obj_dir/scaler_sim \
    || { echo "Build or simulation failed"; exit 1; }
